// File: logic/vid_macros.svh
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// ====================
// raster geometry
// ====================
`define VID_H_ACTIVE     32
`define VID_H_TOTAL      48
`define VID_HSYNC_START  36
`define VID_HSYNC_END    40
`define VID_V_ACTIVE     8
`define VID_V_TOTAL      12
`define VID_VSYNC_LINE   9

// ====================
// data path sizes
// ====================
`define VID_WORD_W       128
`define VID_PIX_W        16
`define VID_PIX_PER_WORD 8
// 8 pointer bits, 256 entries
`define VID_FIFO_AW      8

// fetch pauses at or above this fill level
`define VID_FETCH_HIGH   200
`define VID_FRAME_WORDS  32
`define VID_BASE_ADDR    32'h0000_1000

`endif

// File: logic/vid_pkg.sv
`default_nettype none

`include "vid_macros.svh"

package vid_pkg;

	// ====================
	// payload types
	// ====================

	// one frame word from memory, eight pixels packed
	typedef logic [`VID_WORD_W-1:0] vid_word_t;

	// one display pixel
	typedef logic [`VID_PIX_W-1:0] vid_pix_t;

	// word address on the memory port
	typedef logic [31:0] vid_addr_t;

	// fifo fill level, same width as the pointers
	typedef logic [`VID_FIFO_AW-1:0] vid_cnt_t;

	// ====================
	// control types
	// ====================

	// pixel lane within a word, lane 0 in the low bits
	typedef logic [$clog2(`VID_PIX_PER_WORD)-1:0] vid_lane_t;

	// fetch handshake states
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_WAIT
	} vid_fetch_st_t;

endpackage

`default_nettype wire

// File: logic/vid_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module vid_fetch (
	input  wire                      rclk,
	input  wire                      rrst,
	input  wire                      frame_start,
	input  wire vid_pkg::vid_cnt_t   fifo_cnt,
	input  wire                      mem_ack,
	input  wire vid_pkg::vid_word_t  mem_data,
	output logic                     mem_req,
	output vid_pkg::vid_addr_t       mem_addr,
	output logic                     fifo_wr,
	output vid_pkg::vid_word_t       fifo_di
);

	localparam int WCW = $clog2(`VID_FRAME_WORDS + 1);
	localparam logic [WCW-1:0] FRAME_WORDS = WCW'(`VID_FRAME_WORDS);
	localparam vid_pkg::vid_cnt_t FETCH_HIGH = vid_pkg::vid_cnt_t'(`VID_FETCH_HIGH);
	localparam vid_pkg::vid_addr_t BASE_ADDR = `VID_BASE_ADDR;

	vid_pkg::vid_fetch_st_t st;
	// words completed in this frame
	logic [WCW-1:0] word_cnt;
	logic more;
	logic room;
	logic got_word;

	// still words left to fetch this frame
	assign more = word_cnt != FRAME_WORDS;
	// back-pressure from the fifo level
	assign room = fifo_cnt < FETCH_HIGH;
	// ack seen while requesting ends the word
	assign got_word = (st == vid_pkg::FETCH_REQ) && mem_ack;

	assign mem_req = st == vid_pkg::FETCH_REQ;
	// returned data goes straight into the fifo on the ack edge
	assign fifo_wr = got_word;
	assign fifo_di = mem_data;

	// ====================
	// handshake FSM
	// ====================
	always_ff @(posedge rclk) begin
		if (rrst) begin
			st <= vid_pkg::FETCH_IDLE;
		end else begin
			case (st)
				vid_pkg::FETCH_IDLE: begin
					// hold off on frame_start so the reload lands first
					if (!frame_start && more && room && !mem_ack) begin
						st <= vid_pkg::FETCH_REQ;
					end
				end
				vid_pkg::FETCH_REQ: begin
					if (mem_ack) begin
						st <= vid_pkg::FETCH_WAIT;
					end
				end
				vid_pkg::FETCH_WAIT: begin
					// four-phase, wait for ack to fall
					if (!mem_ack) begin
						st <= vid_pkg::FETCH_IDLE;
					end
				end
				default: st <= vid_pkg::FETCH_IDLE;
			endcase
		end
	end

	// address and word count, reloaded every frame
	always_ff @(posedge rclk) begin
		if (rrst) begin
			// nothing to fetch until the first frame_start
			mem_addr <= BASE_ADDR;
			word_cnt <= FRAME_WORDS;
		end else if (frame_start) begin
			mem_addr <= BASE_ADDR;
			word_cnt <= '0;
		end else if (got_word) begin
			mem_addr <= mem_addr + 1'b1;
			word_cnt <= word_cnt + 1'b1;
		end
	end

	// frame reload only lands between handshakes
	a_reload_idle: assert property (@(posedge rclk) disable iff (rrst)
		frame_start |-> st == vid_pkg::FETCH_IDLE);

	// memory sees a stable address for the whole request
	a_addr_hold: assert property (@(posedge rclk) disable iff (rrst)
		mem_req |=> !mem_req || $stable(mem_addr));

	// one write per ack, taken on its rising edge
	a_wr_on_ack: assert property (@(posedge rclk) disable iff (rrst)
		fifo_wr |-> $rose(mem_ack));

endmodule

`default_nettype wire

// File: logic/vid_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module vid_fifo (
	input  wire                      rclk,
	input  wire                      rrst,
	input  wire                      clear,
	input  wire                      wr,
	input  wire vid_pkg::vid_word_t  di,
	input  wire                      rd,
	output vid_pkg::vid_word_t       dout,
	output vid_pkg::vid_cnt_t        cnt
);

	localparam int DEPTH = 1 << `VID_FIFO_AW;
	// count wraps, so one slot is kept free
	localparam vid_pkg::vid_cnt_t CNT_FULL = '1;

	vid_pkg::vid_word_t mem [0:DEPTH-1];
	logic [`VID_FIFO_AW-1:0] wr_ptr;
	logic [`VID_FIFO_AW-1:0] rd_ptr;

	// ====================
	// storage
	// ====================

	// data array has no reset
	always_ff @(posedge rclk) begin
		if (wr) begin
			mem[wr_ptr] <= di;
		end
	end

	// ====================
	// pointers
	// ====================
	always_ff @(posedge rclk) begin
		if (rrst || clear) begin
			wr_ptr <= '0;
		end else if (wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge rclk) begin
		if (rrst || clear) begin
			rd_ptr <= '0;
		end else if (rd) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// show-ahead, head word always on dout
	assign dout = mem[rd_ptr];

	// pointer difference, modulo depth
	assign cnt = wr_ptr - rd_ptr;

	a_no_overflow: assert property (@(posedge rclk) disable iff (rrst)
		wr && !clear |-> cnt != CNT_FULL);

	a_no_underflow: assert property (@(posedge rclk) disable iff (rrst)
		rd && !clear |-> cnt != '0);

endmodule

`default_nettype wire

// File: logic/vid_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module vid_unpack (
	input  wire                      rclk,
	input  wire                      rrst,
	input  wire                      de,
	input  wire                      hsync,
	input  wire                      vsync,
	input  wire                      frame_start,
	input  wire vid_pkg::vid_word_t  fifo_dout,
	input  wire vid_pkg::vid_cnt_t   fifo_cnt,
	output logic                     fifo_rd,
	output vid_pkg::vid_pix_t        pix,
	output logic                     pix_de,
	output logic                     pix_hsync,
	output logic                     pix_vsync,
	output logic                     underrun
);

	localparam vid_pkg::vid_lane_t LANE_LAST =
		vid_pkg::vid_lane_t'(`VID_PIX_PER_WORD - 1);

	vid_pkg::vid_lane_t lane;
	logic avail;
	logic take;
	vid_pkg::vid_pix_t lane_pix;

	// head word present
	assign avail = fifo_cnt != '0;
	// display wants a pixel and there is one
	assign take = de && avail;

	// lane 0 sits in the low bits of the word
	assign lane_pix = fifo_dout[lane * `VID_PIX_W +: `VID_PIX_W];

	// pop once the last lane has gone out
	assign fifo_rd = take && (lane == LANE_LAST);

	// ====================
	// lane and underrun
	// ====================
	always_ff @(posedge rclk) begin
		if (rrst) begin
			lane <= '0;
			underrun <= 1'b0;
		end else if (frame_start) begin
			lane <= '0;
			underrun <= 1'b0;
		end else if (de) begin
			if (avail) begin
				lane <= lane + 1'b1;
			end else begin
				// display cannot wait, flag stays until next frame
				underrun <= 1'b1;
			end
		end
	end

	// ====================
	// output stage
	// ====================

	// syncs delayed one cycle to line up with pix
	always_ff @(posedge rclk) begin
		if (rrst) begin
			pix_de <= 1'b0;
			pix_hsync <= 1'b0;
			pix_vsync <= 1'b0;
		end else begin
			pix_de <= de;
			pix_hsync <= hsync;
			pix_vsync <= vsync;
		end
	end

	// black when starved
	always_ff @(posedge rclk) begin
		pix <= take ? lane_pix : '0;
	end

endmodule

`default_nettype wire

// File: logic/vid_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module vid_timing (
	input  wire  rclk,
	input  wire  rrst,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic frame_start
);

	localparam int HW = $clog2(`VID_H_TOTAL);
	localparam int VW = $clog2(`VID_V_TOTAL);

	// ====================
	// horizontal limits
	// ====================
	localparam logic [HW-1:0] H_ACTIVE = HW'(`VID_H_ACTIVE);
	localparam logic [HW-1:0] H_LAST   = HW'(`VID_H_TOTAL - 1);
	localparam logic [HW-1:0] HS_START = HW'(`VID_HSYNC_START);
	localparam logic [HW-1:0] HS_END   = HW'(`VID_HSYNC_END);

	// ====================
	// vertical limits
	// ====================
	localparam logic [VW-1:0] V_ACTIVE = VW'(`VID_V_ACTIVE);
	localparam logic [VW-1:0] V_LAST   = VW'(`VID_V_TOTAL - 1);
	localparam logic [VW-1:0] VS_LINE  = VW'(`VID_VSYNC_LINE);

	// pixel within line
	logic [HW-1:0] h_cnt;
	// line within frame
	logic [VW-1:0] v_cnt;
	logic line_end;

	assign line_end = h_cnt == H_LAST;

	always_ff @(posedge rclk) begin
		if (rrst) begin
			h_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// start in the first blanking line so fetch can prefill
	always_ff @(posedge rclk) begin
		if (rrst) begin
			v_cnt <= V_ACTIVE;
		end else if (line_end) begin
			if (v_cnt == V_LAST) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end
	end

	// decoded straight from the counters
	assign de = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
	assign hsync = (h_cnt >= HS_START) && (h_cnt < HS_END);
	// whole line of vsync
	assign vsync = v_cnt == VS_LINE;

	// first cycle of the first blanking line, including the one right after reset
	assign frame_start = (h_cnt == '0) && (v_cnt == V_ACTIVE);

endmodule

`default_nettype wire

// File: logic/vid_scanout.sv
`timescale 1ns/1ps
`default_nettype none

module vid_scanout (
	input  wire                      rclk,
	input  wire                      rrst,
	output logic                     mem_req,
	output vid_pkg::vid_addr_t       mem_addr,
	input  wire                      mem_ack,
	input  wire vid_pkg::vid_word_t  mem_data,
	output vid_pkg::vid_pix_t        pix,
	output logic                     pix_de,
	output logic                     pix_hsync,
	output logic                     pix_vsync,
	output logic                     underrun
);

	// fetch to fifo
	logic fifo_wr;
	vid_pkg::vid_word_t fifo_di;
	// fifo to fetch and unpack
	vid_pkg::vid_word_t fifo_dout;
	vid_pkg::vid_cnt_t fifo_cnt;
	logic fifo_rd;
	// raster pacing
	logic frame_start;
	logic de;
	logic hsync;
	logic vsync;

	// ====================
	// raster timing
	// ====================
	vid_timing i_vid_timing (
		.rclk        (rclk),
		.rrst        (rrst),
		.de          (de),
		.hsync       (hsync),
		.vsync       (vsync),
		.frame_start (frame_start)
	);

	// ====================
	// pipeline
	// ====================
	vid_fetch i_vid_fetch (
		.rclk        (rclk),
		.rrst        (rrst),
		.frame_start (frame_start),
		.fifo_cnt    (fifo_cnt),
		.mem_ack     (mem_ack),
		.mem_data    (mem_data),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.fifo_wr     (fifo_wr),
		.fifo_di     (fifo_di)
	);

	// leftovers from a starved frame are dropped at frame start
	vid_fifo i_vid_fifo (
		.rclk  (rclk),
		.rrst  (rrst),
		.clear (frame_start),
		.wr    (fifo_wr),
		.di    (fifo_di),
		.rd    (fifo_rd),
		.dout  (fifo_dout),
		.cnt   (fifo_cnt)
	);

	vid_unpack i_vid_unpack (
		.rclk        (rclk),
		.rrst        (rrst),
		.de          (de),
		.hsync       (hsync),
		.vsync       (vsync),
		.frame_start (frame_start),
		.fifo_dout   (fifo_dout),
		.fifo_cnt    (fifo_cnt),
		.fifo_rd     (fifo_rd),
		.pix         (pix),
		.pix_de      (pix_de),
		.pix_hsync   (pix_hsync),
		.pix_vsync   (pix_vsync),
		.underrun    (underrun)
	);

endmodule

`default_nettype wire

// File: sim/tb_vid_scanout.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module tb_vid_scanout;

	localparam int CLK_HALF = 20;
	localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
	// four normal frames, then one starved frame
	localparam int NUM_FRAMES = 5;
	localparam int STALL_FRAME = NUM_FRAMES - 1;
	localparam int STALL_CYCLES = 300;
	localparam int RUN_CYCLES = NUM_FRAMES * FRAME_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;
	localparam int FRAME_WORDS = `VID_FRAME_WORDS;
	localparam int PPW = `VID_PIX_PER_WORD;
	localparam vid_pkg::vid_addr_t BASE_ADDR = `VID_BASE_ADDR;

	// memory responder states
	localparam int R_IDLE = 0;
	localparam int R_WAIT = 1;
	localparam int R_ACK = 2;
	localparam int R_DROP = 3;

	// run trackers, indexed by signal
	localparam int T_DE = 0;
	localparam int T_HS = 1;
	localparam int T_VS = 2;

	logic rclk;
	logic rrst;
	logic mem_req;
	vid_pkg::vid_addr_t mem_addr;
	logic mem_ack;
	vid_pkg::vid_word_t mem_data;
	vid_pkg::vid_pix_t pix;
	logic pix_de;
	logic pix_hsync;
	logic pix_vsync;
	logic underrun;

	integer seed;
	int errors;
	int cyc;
	int frame;
	// frame content, word k sits at BASE_ADDR + k
	vid_pkg::vid_word_t frame_mem [0:FRAME_WORDS-1];

	// responder and model state, cleared each frame
	int rsp_st;
	int rsp_cnt;
	int req_idx;
	logic req_prev;
	int words_acked;
	int acked_d1;
	int acked_d2;
	int pix_idx;
	int de_cycles;
	logic model_ur;
	logic ur_seen;
	logic run_prev [0:2];
	int run_len [0:2];
	int run_rises [0:2];

	vid_scanout i_vid_scanout (
		.rclk      (rclk),
		.rrst      (rrst),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_data  (mem_data),
		.pix       (pix),
		.pix_de    (pix_de),
		.pix_hsync (pix_hsync),
		.pix_vsync (pix_vsync),
		.underrun  (underrun)
	);

	initial begin
		rclk = 1'b0;
		forever #CLK_HALF rclk = ~rclk;
	end

	// ====================
	// compare tasks
	// ====================
	task automatic check_pix(input vid_pkg::vid_pix_t got, input vid_pkg::vid_pix_t exp,
		input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input vid_pkg::vid_addr_t got, input vid_pkg::vid_addr_t exp,
		input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// lane k of word w is pixel w*8+k of the frame
	function automatic vid_pkg::vid_pix_t model_pixel(input int idx);
		vid_pkg::vid_word_t w;
		w = frame_mem[idx / PPW];
		return w[(idx % PPW) * `VID_PIX_W +: `VID_PIX_W];
	endfunction

	// ====================
	// raster checks
	// ====================
	task automatic track_run(input int k, input logic now, input int want, input string what);
		if (now && !run_prev[k]) begin
			run_rises[k]++;
			run_len[k] = 0;
		end
		if (now) begin
			run_len[k]++;
		end
		// run length is judged when the pulse ends
		if (!now && run_prev[k]) begin
			check_count(run_len[k], want, what);
		end
		run_prev[k] = now;
	endtask

	task automatic open_frame();
		int k;
		req_idx = 0;
		words_acked = 0;
		acked_d1 = 0;
		acked_d2 = 0;
		pix_idx = 0;
		de_cycles = 0;
		model_ur = 1'b0;
		ur_seen = 1'b0;
		for (k = 0; k < 3; k++) begin
			run_prev[k] = 1'b0;
			run_len[k] = 0;
			run_rises[k] = 0;
		end
	endtask

	task automatic close_frame(input int f);
		check_count(de_cycles, `VID_H_ACTIVE * `VID_V_ACTIVE, "pixels per frame");
		check_count(run_rises[T_DE], `VID_V_ACTIVE, "active lines per frame");
		check_count(run_rises[T_HS], `VID_V_TOTAL, "hsync pulses per frame");
		check_count(run_rises[T_VS], 1, "vsync lines per frame");
		check_count(req_idx, FRAME_WORDS, "requests per frame");
		if (f == STALL_FRAME) begin
			check_flag(ur_seen, 1'b1, "underrun raised in starved frame");
		end
	endtask

	// ====================
	// pixel model
	// ====================
	task automatic check_pixels();
		logic word_ok;
		if (pix_de) begin
			de_cycles++;
			// a word acked two samples back is already at the fifo head
			word_ok = acked_d2 > (pix_idx / PPW);
			if (word_ok) begin
				if (frame != STALL_FRAME) begin
					check_pix(pix, model_pixel(pix_idx), "pixel");
				end
				pix_idx++;
			end else begin
				check_pix(pix, '0, "starved pixel");
				model_ur = 1'b1;
			end
		end
		if (frame == STALL_FRAME) begin
			check_flag(underrun, model_ur, "sticky underrun");
		end else begin
			check_flag(underrun, 1'b0, "underrun in normal frame");
		end
		if (underrun) begin
			ur_seen = 1'b1;
		end
	endtask

	// ====================
	// memory responder
	// ====================
	task automatic respond();
		vid_pkg::vid_addr_t off;
		// four-phase, new request only once ack is low
		if (mem_req && !req_prev) begin
			check_flag(mem_ack, 1'b0, "ack low at new request");
		end
		req_prev = mem_req;
		if (rsp_st == R_IDLE && mem_req) begin
			check_addr(mem_addr, vid_pkg::vid_addr_t'(BASE_ADDR + req_idx), "request address");
			if (frame == STALL_FRAME && req_idx == 0) begin
				rsp_cnt = STALL_CYCLES;
			end else begin
				rsp_cnt = int'($unsigned($random(seed)) % 3);
			end
			req_idx++;
			rsp_st = R_WAIT;
		end
		if (rsp_st == R_WAIT) begin
			if (rsp_cnt == 0) begin
				off = mem_addr - BASE_ADDR;
				if (off < FRAME_WORDS) begin
					mem_data = frame_mem[off];
				end else begin
					$display("request address %h lies outside the frame", mem_addr);
					errors++;
					mem_data = '0;
				end
				mem_ack = 1'b1;
				words_acked++;
				rsp_st = R_ACK;
			end else begin
				rsp_cnt--;
			end
		end
		if (rsp_st == R_ACK && !mem_req) begin
			rsp_cnt = int'($unsigned($random(seed)) % 3);
			rsp_st = R_DROP;
		end
		if (rsp_st == R_DROP) begin
			if (rsp_cnt == 0) begin
				mem_ack = 1'b0;
				rsp_st = R_IDLE;
			end else begin
				rsp_cnt--;
			end
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int i;
		rrst = 1'b1;
		mem_ack = 1'b0;
		mem_data = '0;
		seed = 32'hc587_cea8;
		errors = 0;
		rsp_st = R_IDLE;
		rsp_cnt = 0;
		req_prev = 1'b0;
		frame = 0;
		for (i = 0; i < FRAME_WORDS; i++) begin
			frame_mem[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
		open_frame();
		repeat (3) @(negedge rclk);
		// quiet outputs before the first frame_start
		check_flag(mem_req, 1'b0, "mem_req after reset");
		check_flag(pix_de, 1'b0, "pix_de after reset");
		check_flag(underrun, 1'b0, "underrun after reset");
		rrst = 1'b0;
		// cyc 0 samples just after the first frame_start edge
		for (cyc = 0; cyc <= RUN_CYCLES; cyc++) begin
			@(negedge rclk);
			frame = cyc / FRAME_CYCLES;
			if (cyc % FRAME_CYCLES == 0) begin
				if (cyc != 0) begin
					close_frame(frame - 1);
				end
				open_frame();
			end
			if (cyc < RUN_CYCLES) begin
				track_run(T_DE, pix_de, `VID_H_ACTIVE, "pix_de run");
				track_run(T_HS, pix_hsync, `VID_HSYNC_END - `VID_HSYNC_START, "hsync run");
				track_run(T_VS, pix_vsync, `VID_H_TOTAL, "vsync run");
				check_pixels();
				respond();
				acked_d2 = acked_d1;
				acked_d1 = words_acked;
			end
		end
		check_flag(underrun, 1'b0, "underrun cleared at frame start");
		$display("run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge rclk);
		$display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/vid_pkg.sv
logic/vid_fetch.sv
logic/vid_fifo.sv
logic/vid_unpack.sv
logic/vid_timing.sv
logic/vid_scanout.sv
sim/tb_vid_scanout.sv

// File: Makefile
# Verilator flow for the video scanout testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_vid_scanout
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
